// File: logic/rv_hazard_macros.svh
/*
 * widths, opcodes and flush length shared by the decode hazard unit
 * include wherever one of these constants is needed
 */
`ifndef RV_HAZARD_MACROS_SVH
`define RV_HAZARD_MACROS_SVH

// datapath widths
`define RV_XLEN          32
`define RV_REG_W         5         // x0..x31

// opcodes handled in decode
`define RV_OP_BRANCH     7'b1100011
`define RV_OP_JAL        7'b1101111
`define RV_OP_JALR       7'b1100111

// funct3 of the early-resolved branches
`define RV_FUNCT3_BEQ    3'b000
`define RV_FUNCT3_BNE    3'b001

// flush window after a redirect, in cycles
`define RV_FLUSH_CYCLES  2
`define RV_FLUSH_CNT_W   2         // wide enough for RV_FLUSH_CYCLES

`endif

// File: logic/rv_hazard_pkg.sv
/*
 * vector, enum and struct types of the decode hazard unit
 * modules import this inside their body
 */
`default_nettype none

`include "rv_hazard_macros.svh"

package rv_hazard_pkg;

    typedef logic [`RV_XLEN-1:0]  xlen_t;      // data word or address
    typedef logic [`RV_REG_W-1:0] reg_idx_t;   // register index
    typedef logic [31:0]          inst_t;      // raw instruction

    // forwarding source of an operand
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,   // register file read
        FWD_WB  = 2'b01,   // MEM/WB write-back data
        FWD_MEM = 2'b10    // EX/MEM alu result
    } fwd_sel_e;

    typedef struct packed {
        xlen_t pc;
        inst_t inst;
    } id_inst_t;                               // 64 bits

    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     reg_we;                      // active high
        logic     mem_read;                    // load in EX
    } id_ex_info_t;                            // 17 bits

    typedef struct packed {
        reg_idx_t rd;
        logic     reg_we;
        logic     mem_read;                    // load in MEM with data not ready yet
        xlen_t    alu_result;
    } ex_mem_info_t;                           // 39 bits

    typedef struct packed {
        reg_idx_t rd;
        logic     reg_we;
        xlen_t    wb_data;
    } mem_wb_info_t;                           // 38 bits

    typedef struct packed {
        logic     is_beq;
        logic     is_bne;
        logic     is_jal;
        logic     is_jalr;
        logic     uses_rs1;
        logic     uses_rs2;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    imm;                         // sign-extended B, J or I immediate
    } inst_class_t;                            // 48 bits

    typedef struct packed {
        logic  taken;
        xlen_t target;
    } redirect_t;                              // 33 bits

endpackage

`default_nettype wire

// File: logic/inst_classifier.sv
/*
 * decode-stage classification: beq/bne/jal/jalr flags, operand use,
 * register indices and the sign-extended immediate
 */
`timescale 1ns/100ps
`default_nettype none

`include "rv_hazard_macros.svh"

module inst_classifier (
    input  wire rv_hazard_pkg::id_inst_t    id_inst_i,
    output rv_hazard_pkg::inst_class_t      cls_o
);
    import rv_hazard_pkg::*;

    inst_t      inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_branch;             // any conditional branch opcode
    xlen_t      imm_b, imm_j, imm_i;

    assign inst   = id_inst_i.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    // immediates, bit 0 of B/J is implicit zero
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_i = {{20{inst[31]}}, inst[31:20]};

    assign is_branch = (opcode == `RV_OP_BRANCH);

    always_comb begin
        cls_o          = '0;
        cls_o.rs1      = inst[19:15];
        cls_o.rs2      = inst[24:20];
        cls_o.is_beq   = is_branch && (funct3 == `RV_FUNCT3_BEQ);
        cls_o.is_bne   = is_branch && (funct3 == `RV_FUNCT3_BNE);
        cls_o.is_jal   = (opcode == `RV_OP_JAL);
        cls_o.is_jalr  = (opcode == `RV_OP_JALR) && (funct3 == 3'b000);
        // branches read both sources, jalr only rs1, jal none
        cls_o.uses_rs1 = is_branch || cls_o.is_jalr;
        cls_o.uses_rs2 = is_branch;

        case (opcode)
            `RV_OP_BRANCH: cls_o.imm = imm_b;    // pc relative
            `RV_OP_JAL:    cls_o.imm = imm_j;    // pc relative
            `RV_OP_JALR:   cls_o.imm = imm_i;    // rs1 relative
            default:       cls_o.imm = '0;       // not a control transfer
        endcase
    end

endmodule

`default_nettype wire

// File: logic/hazard_ctrl.sv
/*
 * forwarding selects for EX and for the decode compare, plus the stall level
 * stall covers load-use and early branch/jalr operands not yet available
 */
`timescale 1ns/100ps
`default_nettype none

module hazard_ctrl (
    input  wire rv_hazard_pkg::inst_class_t  cls_i,
    input  wire rv_hazard_pkg::id_ex_info_t  id_ex_i,
    input  wire rv_hazard_pkg::ex_mem_info_t ex_mem_i,
    input  wire rv_hazard_pkg::mem_wb_info_t mem_wb_i,
    output rv_hazard_pkg::fwd_sel_e          fwd_a_o,
    output rv_hazard_pkg::fwd_sel_e          fwd_b_o,
    output rv_hazard_pkg::fwd_sel_e          id_sel_a_o,
    output rv_hazard_pkg::fwd_sel_e          id_sel_b_o,
    output logic                             stall_o
);
    import rv_hazard_pkg::*;

    logic needs_early;     // resolved in decode, needs final operand values
    logic id_ex_dep;       // EX instr writes a reg the decode instr reads
    logic ex_mem_ld_dep;   // load in MEM writes a reg the decode instr reads
    logic load_use;

    // writer hits a register index, x0 never forwards
    function automatic logic hit(input logic we, input reg_idx_t rd, input reg_idx_t idx);
        return we && (rd != '0) && (rd == idx);
    endfunction

    // hit on either source actually read by the decode instr
    function automatic logic dep(input logic we, input reg_idx_t rd, input inst_class_t c);
        return (c.uses_rs1 && hit(we, rd, c.rs1)) || (c.uses_rs2 && hit(we, rd, c.rs2));
    endfunction

    // priority pick, youngest producer first
    function automatic fwd_sel_e pick(input reg_idx_t idx, input ex_mem_info_t em,
                                      input mem_wb_info_t mw);
        fwd_sel_e sel;
        if (hit(em.reg_we, em.rd, idx))
            sel = FWD_MEM;
        else if (hit(mw.reg_we, mw.rd, idx))
            sel = FWD_WB;
        else
            sel = FWD_REG;
        return sel;
    endfunction

    // EX operands, against the instr now in ID/EX
    assign fwd_a_o = pick(id_ex_i.rs1, ex_mem_i, mem_wb_i);
    assign fwd_b_o = pick(id_ex_i.rs2, ex_mem_i, mem_wb_i);

    // decode operands for the beq/bne compare and jalr base
    assign id_sel_a_o = pick(cls_i.rs1, ex_mem_i, mem_wb_i);
    assign id_sel_b_o = pick(cls_i.rs2, ex_mem_i, mem_wb_i);

    assign needs_early = cls_i.is_beq || cls_i.is_bne || cls_i.is_jalr;

    assign id_ex_dep     = dep(id_ex_i.reg_we, id_ex_i.rd, cls_i);
    assign ex_mem_ld_dep = ex_mem_i.mem_read && dep(ex_mem_i.reg_we, ex_mem_i.rd, cls_i);

    assign load_use = id_ex_i.mem_read && id_ex_dep;    // any reader of a load

    // result still in EX, or load data still in MEM, too late for decode
    assign stall_o = load_use
                   || (needs_early && id_ex_dep)
                   || (needs_early && ex_mem_ld_dep);

endmodule

`default_nettype wire

// File: logic/branch_resolver.sv
/*
 * decode-stage resolution of beq/bne and jal/jalr
 * forwarded operands compared for equality and target formed as pc or rs1 plus imm
 */
`timescale 1ns/100ps
`default_nettype none

`include "rv_hazard_macros.svh"

module branch_resolver (
    input  wire rv_hazard_pkg::inst_class_t  cls_i,
    input  wire rv_hazard_pkg::xlen_t        pc_i,
    input  wire rv_hazard_pkg::xlen_t        rs1_data_i,
    input  wire rv_hazard_pkg::xlen_t        rs2_data_i,
    input  wire rv_hazard_pkg::ex_mem_info_t ex_mem_i,
    input  wire rv_hazard_pkg::mem_wb_info_t mem_wb_i,
    input  wire rv_hazard_pkg::fwd_sel_e     id_sel_a_i,
    input  wire rv_hazard_pkg::fwd_sel_e     id_sel_b_i,
    input  wire                              stall_i,
    output rv_hazard_pkg::redirect_t         redirect_o
);
    import rv_hazard_pkg::*;

    xlen_t op_a, op_b;     // forwarded rs1 / rs2
    xlen_t base, sum;
    logic  equal;
    logic  cond_taken;

    // 3-way forwarding mux
    function automatic xlen_t fwd_mux(input fwd_sel_e sel, input xlen_t reg_val,
                                      input xlen_t mem_val, input xlen_t wb_val);
        xlen_t val;
        case (sel)
            FWD_MEM: val = mem_val;
            FWD_WB:  val = wb_val;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    assign op_a = fwd_mux(id_sel_a_i, rs1_data_i, ex_mem_i.alu_result, mem_wb_i.wb_data);
    assign op_b = fwd_mux(id_sel_b_i, rs2_data_i, ex_mem_i.alu_result, mem_wb_i.wb_data);

    assign equal      = (op_a == op_b);
    assign cond_taken = (cls_i.is_beq && equal) || (cls_i.is_bne && !equal);

    assign base = cls_i.is_jalr ? op_a : pc_i;   // jalr is rs1 relative
    assign sum  = base + cls_i.imm;

    // stalled instr redirects once its operands are in
    assign redirect_o.taken  = !stall_i && (cls_i.is_jal || cls_i.is_jalr || cond_taken);
    assign redirect_o.target = cls_i.is_jalr ? {sum[`RV_XLEN-1:1], 1'b0} : sum;

endmodule

`default_nettype wire

// File: logic/flush_ctrl.sv
/*
 * flush window after a taken redirect
 * loads only when idle, flush_o high while the count is non-zero
 */
`timescale 1ns/100ps
`default_nettype none

`include "rv_hazard_macros.svh"

module flush_ctrl (
    input  wire  clk,
    input  wire  rst_n_i,
    input  wire  redirect_taken_i,
    output logic flush_o
);
    logic [`RV_FLUSH_CNT_W-1:0] cnt_q, cnt_d;

    always_comb begin
        if (cnt_q != '0)
            cnt_d = cnt_q - 1'b1;                                 // window running, no reload
        else if (redirect_taken_i)
            cnt_d = `RV_FLUSH_CNT_W'(`RV_FLUSH_CYCLES);           // open window
        else
            cnt_d = '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cnt_q   <= '0;
            flush_o <= 1'b0;
        end else begin
            cnt_q   <= cnt_d;
            flush_o <= (cnt_d != '0);    // tracks cnt_q != 0
        end
    end

endmodule

`default_nettype wire

// File: logic/branch_hazard_top.sv
/*
 * decode hazard unit top: classifier, hazard control, branch resolver, flush
 * redirect and stall are combinational, flush is registered
 */
`timescale 1ns/100ps
`default_nettype none

module branch_hazard_top (
    input  wire                              clk,
    input  wire                              rst_n_i,
    input  wire rv_hazard_pkg::id_inst_t     id_inst_i,
    input  wire rv_hazard_pkg::xlen_t        rs1_data_i,
    input  wire rv_hazard_pkg::xlen_t        rs2_data_i,
    input  wire rv_hazard_pkg::id_ex_info_t  id_ex_i,
    input  wire rv_hazard_pkg::ex_mem_info_t ex_mem_i,
    input  wire rv_hazard_pkg::mem_wb_info_t mem_wb_i,
    output rv_hazard_pkg::fwd_sel_e          fwd_a_o,
    output rv_hazard_pkg::fwd_sel_e          fwd_b_o,
    output logic                             stall_o,
    output rv_hazard_pkg::redirect_t         redirect_o,
    output logic                             flush_o
);
    import rv_hazard_pkg::*;

    inst_class_t cls;                  // decoded decode-stage instr
    fwd_sel_e    id_sel_a, id_sel_b;   // decode operand sources

    inst_classifier u_classifier (
        .id_inst_i (id_inst_i),
        .cls_o     (cls)
    );

    hazard_ctrl u_hazard (
        .cls_i      (cls),
        .id_ex_i    (id_ex_i),
        .ex_mem_i   (ex_mem_i),
        .mem_wb_i   (mem_wb_i),
        .fwd_a_o    (fwd_a_o),
        .fwd_b_o    (fwd_b_o),
        .id_sel_a_o (id_sel_a),
        .id_sel_b_o (id_sel_b),
        .stall_o    (stall_o)
    );

    branch_resolver u_resolver (
        .cls_i      (cls),
        .pc_i       (id_inst_i.pc),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .ex_mem_i   (ex_mem_i),
        .mem_wb_i   (mem_wb_i),
        .id_sel_a_i (id_sel_a),
        .id_sel_b_i (id_sel_b),
        .stall_i    (stall_o),
        .redirect_o (redirect_o)
    );

    flush_ctrl u_flush (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .redirect_taken_i (redirect_o.taken),
        .flush_o          (flush_o)
    );

endmodule

`default_nettype wire

// File: tb/tb_vectors.svh
/*
 * stimulus and expected-value table for the decode hazard unit testbench
 * included inside the testbench module body, after the package import
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
    fwd_sel_e   fa;        // expected fwd_a_o
    fwd_sel_e   fb;        // expected fwd_b_o
    logic       stall;
    logic       taken;
    logic       same;      // forwarded operands made equal
    logic [3:0] hold;      // cycles the inputs stay applied
} expect_t;

typedef struct packed {
    logic [6:0]   op;
    logic [2:0]   f3;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    xlen_t        imm;
    xlen_t        pc;
    id_ex_info_t  ix;      // rs1, rs2, rd, reg_we, mem_read
    ex_mem_info_t em;      // rd, reg_we, mem_read, data drawn later
    mem_wb_info_t wb;      // rd, reg_we, data drawn later
    expect_t      ex;
} vec_t;

vec_t vecs[$];

task automatic add_vec(input logic [6:0] op, input logic [2:0] f3,
                       input reg_idx_t rs1, input reg_idx_t rs2,
                       input xlen_t imm, input xlen_t pc,
                       input id_ex_info_t ix, input ex_mem_info_t em,
                       input mem_wb_info_t wb, input expect_t ex);
    vec_t v;
    v.op  = op;
    v.f3  = f3;
    v.rs1 = rs1;
    v.rs2 = rs2;
    v.imm = imm;
    v.pc  = pc;
    v.ix  = ix;
    v.em  = em;
    v.wb  = wb;
    v.ex  = ex;
    vecs.push_back(v);
endtask

// columns: op f3 rs1 rs2 imm pc | id_ex | ex_mem | mem_wb | fa fb stall taken same hold
task automatic load_table();
    // EX forwarding priority, R-type in decode so nothing resolves there
    add_vec(7'b0110011, 3'd0, 5'd0, 5'd0, 32'h0, 32'h80, '{5'd3, 5'd4, 5'd0, 1'b0, 1'b0},
            '{5'd3, 1'b1, 1'b0, 32'h0}, '{5'd3, 1'b1, 32'h0},
            '{FWD_MEM, FWD_REG, 1'b0, 1'b0, 1'b0, 4'd1});
    add_vec(7'b0110011, 3'd0, 5'd0, 5'd0, 32'h0, 32'h84, '{5'd3, 5'd4, 5'd0, 1'b0, 1'b0},
            '{5'd5, 1'b1, 1'b0, 32'h0}, '{5'd4, 1'b1, 32'h0},
            '{FWD_REG, FWD_WB, 1'b0, 1'b0, 1'b0, 4'd1});
    add_vec(7'b0110011, 3'd0, 5'd0, 5'd0, 32'h0, 32'h88, '{5'd0, 5'd3, 5'd0, 1'b0, 1'b0},
            '{5'd0, 1'b1, 1'b0, 32'h0}, '{5'd3, 1'b0, 32'h0},
            '{FWD_REG, FWD_REG, 1'b0, 1'b0, 1'b0, 4'd1});
    add_vec(7'b0110011, 3'd0, 5'd0, 5'd0, 32'h0, 32'h8c, '{5'd3, 5'd4, 5'd0, 1'b0, 1'b0},
            '{5'd3, 1'b0, 1'b0, 32'h0}, '{5'd4, 1'b1, 32'h0},
            '{FWD_REG, FWD_WB, 1'b0, 1'b0, 1'b0, 4'd1});
    // load-use, then the same load to x0
    add_vec(`RV_OP_BRANCH, `RV_FUNCT3_BEQ, 5'd6, 5'd7, 32'h10, 32'h100,
            '{5'd0, 5'd0, 5'd6, 1'b1, 1'b1}, '{5'd0, 1'b0, 1'b0, 32'h0}, '{5'd0, 1'b0, 32'h0},
            '{FWD_REG, FWD_REG, 1'b1, 1'b0, 1'b1, 4'd2});
    add_vec(`RV_OP_BRANCH, `RV_FUNCT3_BEQ, 5'd6, 5'd7, 32'h10, 32'h100,
            '{5'd0, 5'd0, 5'd0, 1'b1, 1'b1}, '{5'd0, 1'b0, 1'b0, 32'h0}, '{5'd0, 1'b0, 32'h0},
            '{FWD_REG, FWD_REG, 1'b0, 1'b1, 1'b1, 4'd1});
    add_vec(7'b0110011, 3'd0, 5'd0, 5'd0, 32'h0, 32'h104, '{5'd0, 5'd0, 5'd0, 1'b0, 1'b0},
            '{5'd0, 1'b0, 1'b0, 32'h0}, '{5'd0, 1'b0, 32'h0},
            '{FWD_REG, FWD_REG, 1'b0, 1'b0, 1'b0, 4'd3});
    // beq/bne on forwarded operands
    add_vec(`RV_OP_BRANCH, `RV_FUNCT3_BEQ, 5'd6, 5'd7, 32'h20, 32'h200,
            '{5'd0, 5'd0, 5'd0, 1'b0, 1'b0}, '{5'd6, 1'b1, 1'b0, 32'h0}, '{5'd0, 1'b0, 32'h0},
            '{FWD_REG, FWD_REG, 1'b0, 1'b1, 1'b1, 4'd1});
    add_vec(`RV_OP_BRANCH, `RV_FUNCT3_BEQ, 5'd6, 5'd7, 32'hffff_fff0, 32'h300,
            '{5'd0, 5'd0, 5'd0, 1'b0, 1'b0}, '{5'd0, 1'b0, 1'b0, 32'h0}, '{5'd7, 1'b1, 32'h0},
            '{FWD_REG, FWD_REG, 1'b0, 1'b0, 1'b0, 4'd1});
    add_vec(`RV_OP_BRANCH, `RV_FUNCT3_BNE, 5'd6, 5'd7, 32'hffff_fff0, 32'h400,
            '{5'd0, 5'd0, 5'd0, 1'b0, 1'b0}, '{5'd0, 1'b0, 1'b0, 32'h0}, '{5'd0, 1'b0, 32'h0},
            '{FWD_REG, FWD_REG, 1'b0, 1'b1, 1'b0, 4'd1});
    add_vec(`RV_OP_BRANCH, `RV_FUNCT3_BNE, 5'd6, 5'd7, 32'h40, 32'h440,
            '{5'd0, 5'd0, 5'd0, 1'b0, 1'b0}, '{5'd7, 1'b1, 1'b0, 32'h0}, '{5'd6, 1'b1, 32'h0},
            '{FWD_REG, FWD_REG, 1'b0, 1'b0, 1'b1, 4'd1});
    add_vec(`RV_OP_BRANCH, `RV_FUNCT3_BEQ, 5'd6, 5'd7, 32'hffff_ffc0, 32'h500,
            '{5'd0, 5'd0, 5'd0, 1'b0, 1'b0}, '{5'd6, 1'b1, 1'b0, 32'h0}, '{5'd7, 1'b1, 32'h0},
            '{FWD_REG, FWD_REG, 1'b0, 1'b1, 1'b1, 4'd1});
    // jal, jalr, jalr stalls
    add_vec(`RV_OP_JAL, 3'd0, 5'd0, 5'd0, 32'h800, 32'h600,
            '{5'd0, 5'd0, 5'd0, 1'b0, 1'b0}, '{5'd0, 1'b0, 1'b0, 32'h0}, '{5'd0, 1'b0, 32'h0},
            '{FWD_REG, FWD_REG, 1'b0, 1'b1, 1'b0, 4'd3});
    add_vec(`RV_OP_JAL, 3'd0, 5'd0, 5'd0, 32'hffff_fbfc, 32'h1000,
            '{5'd0, 5'd0, 5'd0, 1'b0, 1'b0}, '{5'd0, 1'b0, 1'b0, 32'h0}, '{5'd0, 1'b0, 32'h0},
            '{FWD_REG, FWD_REG, 1'b0, 1'b1, 1'b0, 4'd3});
    add_vec(`RV_OP_JALR, 3'd0, 5'd9, 5'd0, 32'h13, 32'h1100,
            '{5'd0, 5'd0, 5'd0, 1'b0, 1'b0}, '{5'd9, 1'b1, 1'b0, 32'h0}, '{5'd0, 1'b0, 32'h0},
            '{FWD_REG, FWD_REG, 1'b0, 1'b1, 1'b0, 4'd3});
    add_vec(`RV_OP_JALR, 3'd0, 5'd9, 5'd0, 32'hffff_ffff, 32'h1200,
            '{5'd0, 5'd0, 5'd0, 1'b0, 1'b0}, '{5'd0, 1'b0, 1'b0, 32'h0}, '{5'd9, 1'b1, 32'h0},
            '{FWD_REG, FWD_REG, 1'b0, 1'b1, 1'b0, 4'd3});
    add_vec(`RV_OP_JALR, 3'd0, 5'd9, 5'd0, 32'h4, 32'h1300,
            '{5'd0, 5'd0, 5'd9, 1'b1, 1'b0}, '{5'd0, 1'b0, 1'b0, 32'h0}, '{5'd0, 1'b0, 32'h0},
            '{FWD_REG, FWD_REG, 1'b1, 1'b0, 1'b0, 4'd1});
    add_vec(`RV_OP_JALR, 3'd0, 5'd9, 5'd0, 32'h4, 32'h1300,
            '{5'd0, 5'd0, 5'd0, 1'b0, 1'b0}, '{5'd9, 1'b1, 1'b1, 32'h0}, '{5'd0, 1'b0, 32'h0},
            '{FWD_REG, FWD_REG, 1'b1, 1'b0, 1'b0, 4'd1});
    // taken held over two edges, second one lands inside the window
    add_vec(`RV_OP_JAL, 3'd0, 5'd0, 5'd0, 32'h40, 32'h2000,
            '{5'd0, 5'd0, 5'd0, 1'b0, 1'b0}, '{5'd0, 1'b0, 1'b0, 32'h0}, '{5'd0, 1'b0, 32'h0},
            '{FWD_REG, FWD_REG, 1'b0, 1'b1, 1'b0, 4'd2});
    add_vec(7'b0110011, 3'd0, 5'd0, 5'd0, 32'h0, 32'h2040, '{5'd0, 5'd0, 5'd0, 1'b0, 1'b0},
            '{5'd0, 1'b0, 1'b0, 32'h0}, '{5'd0, 1'b0, 32'h0},
            '{FWD_REG, FWD_REG, 1'b0, 1'b0, 1'b0, 4'd4});
endtask

`endif

// File: tb/tb_branch_hazard.sv
/*
 * testbench for the decode hazard unit that walks the vector table
 * data words come from an LFSR and expected values from the forwarding rules
 */
`timescale 1ns/100ps
`default_nettype none

`include "rv_hazard_macros.svh"

module tb_branch_hazard;
    import rv_hazard_pkg::*;

    `include "tb_vectors.svh"

    logic         clk;
    logic         rst_n_i;
    id_inst_t     id_inst_i;
    xlen_t        rs1_data_i, rs2_data_i;
    id_ex_info_t  id_ex_i;
    ex_mem_info_t ex_mem_i;
    mem_wb_info_t mem_wb_i;
    fwd_sel_e     fwd_a_o, fwd_b_o;
    logic         stall_o, flush_o;
    redirect_t    redirect_o;

    logic [31:0]  lfsr_q = 32'h9f2e_9e8b;
    logic [`RV_FLUSH_CNT_W-1:0] flush_cnt = '0;   // reference flush counter
    logic         model_taken;                    // taken bit seen by the model
    int           cycle_cnt = 0;
    int           cycle_limit = 1000;
    logic         checking_flush = 1'b0;          // flush_o is X until first edge

    branch_hazard_top uut (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .id_inst_i  (id_inst_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .id_ex_i    (id_ex_i),
        .ex_mem_i   (ex_mem_i),
        .mem_wb_i   (mem_wb_i),
        .fwd_a_o    (fwd_a_o),
        .fwd_b_o    (fwd_b_o),
        .stall_o    (stall_o),
        .redirect_o (redirect_o),
        .flush_o    (flush_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
            abort_run($sformatf("timeout after %0d cycles", cycle_cnt));
    end

    // window opens on a taken edge only when idle
    always @(posedge clk) begin
        if (!rst_n_i)
            flush_cnt <= '0;
        else if (flush_cnt != '0)
            flush_cnt <= flush_cnt - 1'b1;
        else if (model_taken)
            flush_cnt <= `RV_FLUSH_CNT_W'(`RV_FLUSH_CYCLES);
    end

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic xlen_t draw_word();
        xlen_t w;
        logic  fb;
        for (int i = 0; i < 32; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            w[i]   = fb;
        end
        return w;
    endfunction

    function automatic inst_t build_inst(input logic [6:0] op, input logic [2:0] f3,
                                         input reg_idx_t rs1, input reg_idx_t rs2,
                                         input xlen_t imm);
        inst_t w;
        case (op)
            `RV_OP_BRANCH: w = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
            `RV_OP_JAL:    w = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, op};
            `RV_OP_JALR:   w = {imm[11:0], rs1, 3'b000, 5'd1, op};
            default:       w = {7'd0, rs2, rs1, 3'b000, 5'd0, op};   // R-type
        endcase
        return w;
    endfunction

    // youngest writer wins and x0 never matches
    function automatic fwd_sel_e source_of(input reg_idx_t idx, input ex_mem_info_t em,
                                           input mem_wb_info_t mw);
        if (em.reg_we && em.rd != '0 && em.rd == idx)
            return FWD_MEM;
        if (mw.reg_we && mw.rd != '0 && mw.rd == idx)
            return FWD_WB;
        return FWD_REG;
    endfunction

    function automatic xlen_t value_from(input fwd_sel_e sel, input xlen_t rf,
                                         input ex_mem_info_t em, input mem_wb_info_t mw);
        if (sel == FWD_MEM)
            return em.alu_result;
        if (sel == FWD_WB)
            return mw.wb_data;
        return rf;
    endfunction

    task automatic check_sel(input string name, input fwd_sel_e got, input fwd_sel_e exp);
        if (got !== exp)
            abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    // target only matters when the redirect is taken
    task automatic check_redirect(input redirect_t got, input redirect_t exp);
        if (got.taken !== exp.taken || (exp.taken && got.target !== exp.target))
            abort_run($sformatf("[FAIL] redirect_o got %h expected %h", got, exp));
    endtask

    task automatic apply_vec(input vec_t v, output redirect_t exp_r);
        xlen_t        rs1d, rs2d, alu, wbd, a_val, b_val, sum;
        fwd_sel_e     sa, sb;
        ex_mem_info_t em;
        mem_wb_info_t mw;
        rs1d          = draw_word();
        rs2d          = draw_word();
        alu           = draw_word();
        wbd           = draw_word();
        em            = v.em;
        mw            = v.wb;
        em.alu_result = alu;
        mw.wb_data    = wbd;
        sa    = source_of(v.rs1, em, mw);
        sb    = source_of(v.rs2, em, mw);
        a_val = value_from(sa, rs1d, em, mw);
        if (v.ex.same) begin            // copy rs1 value into rs2's source
            case (sb)
                FWD_MEM: em.alu_result = a_val;
                FWD_WB:  mw.wb_data = a_val;
                default: rs2d = a_val;
            endcase
        end
        b_val = value_from(sb, rs2d, em, mw);
        if (!v.ex.same && a_val == b_val && sb == FWD_REG) begin
            rs2d  = ~rs2d;              // unlikely draw collision
            b_val = rs2d;
        end
        id_inst_i  = '{v.pc, build_inst(v.op, v.f3, v.rs1, v.rs2, v.imm)};
        rs1_data_i = rs1d;
        rs2_data_i = rs2d;
        id_ex_i    = v.ix;
        ex_mem_i   = em;
        mem_wb_i   = mw;
        if (v.op == `RV_OP_JALR) begin
            sum          = a_val + v.imm;
            exp_r.target = {sum[31:1], 1'b0};
        end else begin
            exp_r.target = v.pc + v.imm;
        end
        exp_r.taken = v.ex.taken;
    endtask

    task automatic drive_idle();
        id_inst_i  = '{32'h0, build_inst(7'b0110011, 3'd0, 5'd0, 5'd0, 32'h0)};
        rs1_data_i = '0;
        rs2_data_i = '0;
        id_ex_i    = '0;
        ex_mem_i   = '0;
        mem_wb_i   = '0;
    endtask

    always @(negedge clk) begin
        if (checking_flush)
            check_bit("flush_o", flush_o, flush_cnt != '0);
    end

    initial begin
        redirect_t exp_r;
        int        total;
        rst_n_i     = 1'b0;
        model_taken = 1'b0;
        drive_idle();
        // a taken jal during reset must not open a window
        id_inst_i = '{32'h40, build_inst(`RV_OP_JAL, 3'd0, 5'd0, 5'd0, 32'h100)};
        load_table();
        total = 0;
        foreach (vecs[i])
            total += vecs[i].ex.hold;
        cycle_limit = total + 4 + 4 + 20;   // table plus reset plus drain plus margin
        @(posedge clk);
        checking_flush = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        drive_idle();
        rst_n_i = 1'b1;
        foreach (vecs[i]) begin
            for (int h = 0; h < vecs[i].ex.hold; h++) begin
                if (h != 0)
                    @(negedge clk);
                else begin
                    apply_vec(vecs[i], exp_r);
                    model_taken = exp_r.taken;
                end
                #1;
                check_sel("fwd_a_o", fwd_a_o, vecs[i].ex.fa);
                check_sel("fwd_b_o", fwd_b_o, vecs[i].ex.fb);
                check_bit("stall_o", stall_o, vecs[i].ex.stall);
                check_redirect(redirect_o, exp_r);
            end
            @(negedge clk);
        end
        drive_idle();
        model_taken = 1'b0;
        repeat (4) @(negedge clk);          // let the last window drain
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+logic
+incdir+tb
logic/rv_hazard_pkg.sv
logic/inst_classifier.sv
logic/hazard_ctrl.sv
logic/branch_resolver.sv
logic/flush_ctrl.sv
logic/branch_hazard_top.sv
tb/tb_branch_hazard.sv

// File: Makefile
# Verilator build and run of the decode hazard unit testbench

VERILATOR ?= verilator
TOP       ?= tb_branch_hazard
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
